// File: source/minimac_pkg.sv
/*
 * Shared constants for the MAC frame-buffer subsystem.
 * Holds the CSR map, slot encodings and buffer sizes.
 * Every block refers to these by scoped name.
 */
`default_nettype none

package minimac_pkg;

	// Bank select compared against csr_a[13:10]
	localparam logic [3:0] CSR_BANK = 4'h0;

	// Register indices within the bank, taken from csr_a[4:0]
	localparam logic [4:0] REG_CTRL     = 5'd0;
	localparam logic [4:0] REG_MAC_HI   = 5'd1;
	localparam logic [4:0] REG_MAC_LO   = 5'd2;
	localparam logic [4:0] REG_MDIO     = 5'd3;
	localparam logic [4:0] REG_TX_ADR   = 5'd16;
	localparam logic [4:0] REG_TX_COUNT = 5'd17;

	/* Each slot has three registers: state, then address, then count */
	localparam int REG_SLOT_BASE = 4;
	localparam int SLOT_STRIDE   = 3;
	localparam int NUM_SLOTS     = 4;

	localparam logic [1:0] SLOT_FREE   = 2'd0; // Not in use
	localparam logic [1:0] SLOT_LOADED = 2'd1; // Host gave it a buffer
	localparam logic [1:0] SLOT_DONE   = 2'd2; // A frame has landed

	localparam logic [47:0] DEFAULT_MACADDR = 48'h02_00_00_ab_cd_ef; // Locally administered

	// 1024 words of 32 bits
	localparam int BUF_AW = 10;

	localparam int COUNT_W = 11; // Enough for a full-size frame
	typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// File: source/minimac_ctlif.sv
/*
 * Control and status register bank of the MAC.
 * Owns the receive slot table, the transmit pointer and byte counter,
 * the MDIO bit-bang bits and both interrupt lines.
 */
`default_nettype none

module minimac_ctlif (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  logic [31:0] csr_di,
	output logic [31:0] csr_do,

	output logic        irq_rx,
	output logic        irq_tx,

	output logic        speed10,
	output logic        promisc,
	output logic [47:0] macaddr,

	output logic        mdc,
	output logic        mdio_o,
	output logic        mdio_oe,
	input  logic        mdio_i,

	output logic        rx_valid,
	output logic [29:0] rx_adr,
	input  logic        rx_incrcount,
	input  logic        rx_endframe,

	output logic        tx_valid,
	output logic [29:0] tx_adr,
	output logic [1:0]  tx_bytecount,
	input  logic        tx_next
);

	logic [1:0]          slot_state [minimac_pkg::NUM_SLOTS];
	logic [29:0]         slot_adr   [minimac_pkg::NUM_SLOTS];
	minimac_pkg::count_t slot_count [minimac_pkg::NUM_SLOTS];
	logic [minimac_pkg::NUM_SLOTS-1:0] slot_sel; // One-hot, lowest LOADED slot

	minimac_pkg::count_t tx_remaining;
	logic                tx_valid_r;
	logic                any_done;
	logic                mdio_meta;
	logic                mdio_sync;
	logic                csr_selected;
	logic [4:0]          csr_reg;
	logic [31:0]         rdata;

	// Register index of field f (0 state, 1 address, 2 count) of slot n
	function automatic logic [4:0] slot_reg(input int n, input int f);
		return 5'(minimac_pkg::REG_SLOT_BASE + minimac_pkg::SLOT_STRIDE * n + f);
	endfunction

	assign csr_selected = csr_a[13:10] == minimac_pkg::CSR_BANK;
	assign csr_reg      = csr_a[4:0];
	assign tx_valid     = |tx_remaining;

	// Two flops on the MDIO input since it comes straight off a pin
	always_ff @(posedge sys_clk) begin
		mdio_meta <= mdio_i;
		mdio_sync <= mdio_meta;
	end

	/* Receive goes to the lowest-numbered slot that holds a buffer */
	always_comb begin
		slot_sel = '0;
		rx_valid = 1'b0;
		rx_adr   = '0;
		any_done = 1'b0;
		for (int i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
			if (slot_state[i] == minimac_pkg::SLOT_LOADED && !rx_valid) begin
				slot_sel[i] = 1'b1;
				rx_valid    = 1'b1;
				rx_adr      = slot_adr[i];
			end
			if (slot_state[i] == minimac_pkg::SLOT_DONE)
				any_done = 1'b1;
		end
	end

	always_comb begin
		rdata = '0;
		case (csr_reg)
			minimac_pkg::REG_CTRL:     rdata = {30'd0, promisc, speed10};
			minimac_pkg::REG_MAC_HI:   rdata = {8'd0, macaddr[47:24]};
			minimac_pkg::REG_MAC_LO:   rdata = {8'd0, macaddr[23:0]};
			minimac_pkg::REG_MDIO:     rdata = {28'd0, mdc, mdio_oe, mdio_sync, mdio_o};
			minimac_pkg::REG_TX_ADR:   rdata = {tx_adr, 2'b00}; // Byte address
			minimac_pkg::REG_TX_COUNT: rdata = 32'(tx_remaining);
			default: ;
		endcase
		for (int i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
			if (csr_reg == slot_reg(i, 0))
				rdata = {30'd0, slot_state[i]};
			if (csr_reg == slot_reg(i, 1))
				rdata = {slot_adr[i], 2'b00};
			if (csr_reg == slot_reg(i, 2))
				rdata = 32'(slot_count[i]); // Read-only from the host side
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_do <= '0;
		else
			csr_do <= csr_selected ? rdata : 32'd0; // Other banks read as zero
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			speed10      <= 1'b0;
			promisc      <= 1'b0;
			macaddr      <= minimac_pkg::DEFAULT_MACADDR;
			mdc          <= 1'b0;
			mdio_oe      <= 1'b0;
			mdio_o       <= 1'b0;
			tx_remaining <= '0;
			tx_adr       <= '0;
			tx_bytecount <= '0;
			for (int i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
				slot_state[i] <= minimac_pkg::SLOT_FREE;
				slot_adr[i]   <= '0;
				slot_count[i] <= '0;
			end
		end else begin
			// Transmitter steps through the frame one byte per transfer
			if (tx_next) begin
				tx_remaining <= tx_remaining - minimac_pkg::count_t'(1);
				tx_bytecount <= tx_bytecount + 2'd1;
				if (tx_bytecount == 2'd3)
					tx_adr <= tx_adr + 30'd1;
			end

			if (csr_selected && csr_we) begin
				case (csr_reg)
					minimac_pkg::REG_CTRL: begin
						promisc <= csr_di[1];
						speed10 <= csr_di[0];
					end
					minimac_pkg::REG_MAC_HI: macaddr[47:24] <= csr_di[23:0];
					minimac_pkg::REG_MAC_LO: macaddr[23:0]  <= csr_di[23:0];
					minimac_pkg::REG_MDIO: begin
						mdc     <= csr_di[3];
						mdio_oe <= csr_di[2];
						mdio_o  <= csr_di[0];
					end
					minimac_pkg::REG_TX_ADR: tx_adr <= csr_di[31:2];
					minimac_pkg::REG_TX_COUNT: begin
						tx_remaining <= csr_di[minimac_pkg::COUNT_W-1:0]; // Starts a transmission
						tx_bytecount <= 2'd0;
					end
					default: ;
				endcase
				for (int i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
					if (csr_reg == slot_reg(i, 0)) begin
						slot_state[i] <= csr_di[1:0];
						slot_count[i] <= '0;
					end
					if (csr_reg == slot_reg(i, 1))
						slot_adr[i] <= csr_di[31:2];
				end
			end

			/* Receiver updates come last and win over a host write in the same cycle */
			for (int i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
				if (slot_sel[i] && rx_incrcount)
					slot_count[i] <= slot_count[i] + minimac_pkg::count_t'(1);
				if (slot_sel[i] && rx_endframe)
					slot_state[i] <= minimac_pkg::SLOT_DONE;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq_rx     <= 1'b0;
			irq_tx     <= 1'b0;
			tx_valid_r <= 1'b0;
		end else begin
			irq_rx     <= any_done; // Level, held until the host frees the slot
			tx_valid_r <= tx_valid;
			irq_tx     <= tx_valid_r & ~tx_valid; // One pulse when the count runs out
		end
	end

endmodule

`default_nettype wire

// File: source/minimac_rx.sv
/*
 * Receive path. Takes the incoming byte stream, packs bytes little-endian
 * into words and writes each finished word into the selected slot.
 * The frame's last byte flushes a partial word and closes the slot.
 */
`default_nettype none

module minimac_rx (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic [7:0]  rx_byte,
	input  logic        rx_byte_valid,
	input  logic        rx_byte_last,
	output logic        rx_byte_ready,

	input  logic        rx_valid,
	input  logic [29:0] rx_adr,
	output logic        rx_incrcount,
	output logic        rx_endframe,

	output logic        dma_wr,
	output logic [29:0] dma_wa,
	output logic [31:0] dma_wd
);

	minimac_pkg::count_t byte_idx; // Position of the next byte in the frame
	logic [1:0]          lane;
	logic [3:0]          lane_en;
	logic [31:0]         asm_word;
	logic                accept;

	assign lane    = byte_idx[1:0];
	assign lane_en = 4'b0001 << lane;

	// Stall for one cycle while a word goes out, and whenever no slot is free
	assign rx_byte_ready = rx_valid & ~dma_wr;
	assign accept        = rx_byte_valid & rx_byte_ready;
	assign rx_incrcount  = accept;
	assign dma_wd        = asm_word; // Stable while dma_wr is high since no byte is taken

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			byte_idx    <= '0;
			dma_wr      <= 1'b0;
			rx_endframe <= 1'b0;
		end else begin
			dma_wr      <= accept & (lane == 2'd3 || rx_byte_last);
			rx_endframe <= accept & rx_byte_last;
			if (accept)
				byte_idx <= rx_byte_last ? '0 : byte_idx + minimac_pkg::count_t'(1);
		end
	end

	/* Assembly register. A byte in lane 0 starts a fresh word, so
	 * lanes past the last byte of a short final word read as zero */
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			for (int j = 0; j < 4; j++) begin
				if (lane_en[j])
					asm_word[8*j +: 8] <= rx_byte;
				else if (lane == 2'd0)
					asm_word[8*j +: 8] <= 8'd0;
			end
			dma_wa <= rx_adr + 30'(byte_idx[minimac_pkg::COUNT_W-1:2]);
		end
	end

endmodule

`default_nettype wire

// File: source/minimac_tx.sv
/*
 * Transmit path. Fetches the word at the current TX pointer from the
 * buffer and hands its bytes out one lane at a time on the byte stream.
 * The control block advances the lane and the pointer on each transfer.
 */
`default_nettype none

module minimac_tx (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic        tx_valid,
	input  logic [29:0] tx_adr,
	input  logic [1:0]  tx_bytecount,
	output logic        tx_next,

	output logic        dma_rd,
	output logic [29:0] dma_ra,
	input  logic        dma_rd_grant,
	input  logic [31:0] dma_rdata,

	output logic [7:0]  tx_byte,
	output logic        tx_byte_valid,
	input  logic        tx_byte_ready
);

	typedef enum logic [1:0] {
		st_empty, // No word held, ask the buffer for one
		st_wait,  // Read granted, data comes back this cycle
		st_hold   // Word held, lanes go out
	} tx_state_t;

	tx_state_t   state;
	logic [31:0] word;

	assign dma_rd = (state == st_empty) && tx_valid; // Retried every cycle until granted
	assign dma_ra = tx_adr;

	// Gated by tx_valid so nothing goes out past the end of the frame
	assign tx_byte_valid = (state == st_hold) && tx_valid;
	assign tx_byte       = word[8*tx_bytecount +: 8];
	assign tx_next       = tx_byte_valid & tx_byte_ready;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_empty;
		end else begin
			case (state)
				st_empty: if (dma_rd_grant) state <= st_wait;
				st_wait:  state <= st_hold;
				st_hold: begin
					if (!tx_valid || (tx_next && tx_bytecount == 2'd3))
						state <= st_empty;
				end
				default: state <= st_empty;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_wait)
			word <= dma_rdata;
	end

endmodule

`default_nettype wire

// File: source/minimac_buffer.sv
/*
 * Shared frame buffer. One port belongs to the host, the other is the
 * DMA port used by receive and transmit. Receive writes always win and
 * a transmit read is only granted in a cycle without a write.
 */
`default_nettype none

module minimac_buffer (
	input  logic                          sys_clk,

	input  logic                          mem_we,
	input  logic [minimac_pkg::BUF_AW-1:0] mem_a,
	input  logic [31:0]                   mem_di,
	output logic [31:0]                   mem_do,

	input  logic                          dma_wr,
	input  logic [29:0]                   dma_wa,
	input  logic [31:0]                   dma_wd,
	input  logic                          dma_rd,
	input  logic [29:0]                   dma_ra,
	output logic                          dma_rd_grant,
	output logic [31:0]                   dma_rdata
);

	logic [31:0] mem [2**minimac_pkg::BUF_AW];

	logic [minimac_pkg::BUF_AW-1:0] dma_wa_w; // Word addresses wrap inside the buffer
	logic [minimac_pkg::BUF_AW-1:0] dma_ra_w;

	assign dma_wa_w     = dma_wa[minimac_pkg::BUF_AW-1:0];
	assign dma_ra_w     = dma_ra[minimac_pkg::BUF_AW-1:0];
	assign dma_rd_grant = dma_rd & ~dma_wr;

	/* Both ports in one block. If host and DMA write the same word
	 * in the same cycle the DMA data is kept */
	always_ff @(posedge sys_clk) begin
		if (mem_we)
			mem[mem_a] <= mem_di;
		if (dma_wr)
			mem[dma_wa_w] <= dma_wd;
		mem_do <= mem[mem_a];
		if (dma_rd_grant)
			dma_rdata <= mem[dma_ra_w]; // Valid the cycle after the grant
	end

endmodule

`default_nettype wire

// File: source/minimac.sv
/*
 * Top level of the MAC frame-buffer subsystem.
 * Connects the register bank, receive path, transmit path and the
 * shared word buffer. The host sees the CSR port and a raw buffer port.
 */
`default_nettype none

module minimac (
	input  logic                          sys_clk,
	input  logic                          sys_rst,

	input  logic [13:0]                   csr_a,
	input  logic                          csr_we,
	input  logic [31:0]                   csr_di,
	output logic [31:0]                   csr_do,

	output logic                          irq_rx,
	output logic                          irq_tx,

	output logic                          speed10,
	output logic                          promisc,
	output logic [47:0]                   macaddr,

	output logic                          mdc,
	output logic                          mdio_o,
	output logic                          mdio_oe,
	input  logic                          mdio_i,

	input  logic                          mem_we,
	input  logic [minimac_pkg::BUF_AW-1:0] mem_a,
	input  logic [31:0]                   mem_di,
	output logic [31:0]                   mem_do,

	input  logic [7:0]                    rx_byte,
	input  logic                          rx_byte_valid,
	input  logic                          rx_byte_last,
	output logic                          rx_byte_ready,

	output logic [7:0]                    tx_byte,
	output logic                          tx_byte_valid,
	input  logic                          tx_byte_ready
);

	// Control to receive path
	logic        rx_valid;
	logic [29:0] rx_adr;
	logic        rx_incrcount;
	logic        rx_endframe;

	// Control to transmit path
	logic        tx_valid;
	logic [29:0] tx_adr;
	logic [1:0]  tx_bytecount;
	logic        tx_next;

	// Shared DMA port of the buffer
	logic        dma_wr;
	logic [29:0] dma_wa;
	logic [31:0] dma_wd;
	logic        dma_rd;
	logic [29:0] dma_ra;
	logic        dma_rd_grant;
	logic [31:0] dma_rdata;

	minimac_ctlif ctlif (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.irq_rx(irq_rx), .irq_tx(irq_tx),
		.speed10(speed10), .promisc(promisc), .macaddr(macaddr),
		.mdc(mdc), .mdio_o(mdio_o), .mdio_oe(mdio_oe), .mdio_i(mdio_i),
		.rx_valid(rx_valid), .rx_adr(rx_adr),
		.rx_incrcount(rx_incrcount), .rx_endframe(rx_endframe),
		.tx_valid(tx_valid), .tx_adr(tx_adr),
		.tx_bytecount(tx_bytecount), .tx_next(tx_next)
	);

	minimac_rx rx (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.rx_byte(rx_byte), .rx_byte_valid(rx_byte_valid),
		.rx_byte_last(rx_byte_last), .rx_byte_ready(rx_byte_ready),
		.rx_valid(rx_valid), .rx_adr(rx_adr),
		.rx_incrcount(rx_incrcount), .rx_endframe(rx_endframe),
		.dma_wr(dma_wr), .dma_wa(dma_wa), .dma_wd(dma_wd)
	);

	minimac_tx tx (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.tx_valid(tx_valid), .tx_adr(tx_adr),
		.tx_bytecount(tx_bytecount), .tx_next(tx_next),
		.dma_rd(dma_rd), .dma_ra(dma_ra),
		.dma_rd_grant(dma_rd_grant), .dma_rdata(dma_rdata),
		.tx_byte(tx_byte), .tx_byte_valid(tx_byte_valid), .tx_byte_ready(tx_byte_ready)
	);

	minimac_buffer buffer (
		.sys_clk(sys_clk),
		.mem_we(mem_we), .mem_a(mem_a), .mem_di(mem_di), .mem_do(mem_do),
		.dma_wr(dma_wr), .dma_wa(dma_wa), .dma_wd(dma_wd),
		.dma_rd(dma_rd), .dma_ra(dma_ra),
		.dma_rd_grant(dma_rd_grant), .dma_rdata(dma_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_minimac.sv
/*
 * Self-checking testbench for the MAC frame-buffer subsystem.
 * Acts as the host on the CSR and buffer ports and models both PHY byte
 * streams with random gaps. Run it through the file list as top module.
 */
`default_nettype none

module tb_minimac;

	localparam int SLOT0_WORD = 256;
	localparam int SLOT1_WORD = 512;
	localparam int SLOT2_WORD = 384;
	localparam int TX_WORD    = 768; // TX frame data lives here

	typedef logic [minimac_pkg::BUF_AW-1:0] word_adr_t;

	logic        sys_clk = 1'b0;
	logic        sys_rst, csr_we, irq_rx, irq_tx, speed10, promisc;
	logic        mdc, mdio_o, mdio_oe, mdio_i, mem_we;
	logic        rx_byte_valid, rx_byte_last, rx_byte_ready;
	logic        tx_byte_valid, tx_byte_ready;
	logic [13:0] csr_a;
	logic [31:0] csr_di, csr_do, mem_di, mem_do;
	logic [47:0] macaddr;
	word_adr_t   mem_a;
	logic [7:0]  rx_byte, tx_byte;

	int          errors;
	int          timeouts;
	int          irq_tx_pulses;
	logic [31:0] seed;
	logic [7:0]  rx_frame [64];
	int          rx_len;
	logic [31:0] tx_words [12];
	logic [7:0]  tx_seen [$]; // Every byte that left on the TX stream

	minimac UUT (.*);

	always #10 sys_clk = ~sys_clk;

	// Mid-cycle the handshake for the coming edge is settled
	always @(negedge sys_clk) begin
		if (tx_byte_valid && tx_byte_ready)
			tx_seen.push_back(tx_byte);
		if (irq_tx)
			irq_tx_pulses++;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [13:0] csr_addr(input logic [4:0] r);
		return {minimac_pkg::CSR_BANK, 5'd0, r};
	endfunction

	/* Field f of slot n, with 0 state, 1 address and 2 count */
	function automatic logic [4:0] slot_field(input int n, input int f);
		return 5'(minimac_pkg::REG_SLOT_BASE + minimac_pkg::SLOT_STRIDE * n + f);
	endfunction

	task automatic check_eq(input string name, input logic [47:0] want, input logic [47:0] got);
		assert (got === want)
		else begin
			$display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic csr_write(input logic [4:0] r, input logic [31:0] d);
		csr_a  = csr_addr(r);
		csr_di = d;
		csr_we = 1'b1;
		step();
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [4:0] r, output logic [31:0] d);
		csr_a = csr_addr(r);
		step();
		d = csr_do; // Data for the address of the previous cycle
	endtask

	task automatic mem_write(input word_adr_t a, input logic [31:0] d);
		mem_a  = a;
		mem_di = d;
		mem_we = 1'b1;
		step();
		mem_we = 1'b0;
	endtask

	task automatic mem_read(input word_adr_t a, output logic [31:0] d);
		mem_a = a;
		step();
		d = mem_do;
	endtask

	task automatic make_frame();
		int i;
		rx_len = 5 + int'(next_rand() >> 8) % 36;
		for (i = 0; i < rx_len; i++)
			rx_frame[i] = 8'(next_rand() >> 24);
	endtask

	task automatic send_frame();
		int  i;
		int  cycles;
		logic ok;
		for (i = 0; i < rx_len; i++) begin
			repeat (int'(next_rand() >> 16) % 3) step(); // Idle gap with valid low
			rx_byte       = rx_frame[i];
			rx_byte_valid = 1'b1;
			rx_byte_last  = (i == rx_len - 1);
			ok            = 1'b0;
			cycles        = 0;
			while (!ok && cycles < 200) begin
				ok = rx_byte_ready;
				step();
				cycles++;
			end
			rx_byte_valid = 1'b0;
			rx_byte_last  = 1'b0;
			if (!ok) begin
				$display("Timeout while receive byte %0d was never accepted", i);
				timeouts++;
				return;
			end
		end
	endtask

	task automatic wait_slot_done(input int n);
		logic [31:0] data;
		int          tries;
		data  = '0;
		tries = 0;
		while (data[1:0] != minimac_pkg::SLOT_DONE && tries < 200) begin
			csr_read(slot_field(n, 0), data);
			tries++;
		end
		if (data[1:0] != minimac_pkg::SLOT_DONE) begin
			$display("Timeout while waiting for slot %0d to reach DONE", n);
			timeouts++;
		end
	endtask

	task automatic check_slot(input int n, input int base);
		logic [31:0] data;
		logic [31:0] want;
		int          w;
		int          j;
		csr_read(slot_field(n, 0), data);
		check_eq("slot state", 48'(minimac_pkg::SLOT_DONE), 48'(data));
		csr_read(slot_field(n, 2), data);
		check_eq("slot count", 48'(rx_len), 48'(data));
		for (w = 0; w < (rx_len + 3) / 4; w++) begin
			want = '0; // Lanes past the frame end stay zero
			for (j = 0; j < 4; j++)
				if (4 * w + j < rx_len)
					want[8 * j +: 8] = rx_frame[4 * w + j];
			mem_read(word_adr_t'(base + w), data);
			check_eq("mem_do", 48'(want), 48'(data));
		end
	endtask

	task automatic fill_tx_words();
		int w;
		for (w = 0; w < 12; w++) begin
			tx_words[w] = next_rand();
			mem_write(word_adr_t'(TX_WORD + w), tx_words[w]);
		end
	endtask

	task automatic run_tx(input int count);
		int          i;
		int          cycles;
		int          first;
		int          pulses0;
		logic [31:0] r;
		logic [31:0] data;
		first   = tx_seen.size();
		pulses0 = irq_tx_pulses;
		csr_write(minimac_pkg::REG_TX_ADR, 32'(TX_WORD * 4));
		csr_write(minimac_pkg::REG_TX_COUNT, 32'(count));
		cycles = 0;
		while (tx_seen.size() - first < count && cycles < 2000) begin
			r             = next_rand();
			tx_byte_ready = r[20];
			step();
			cycles++;
		end
		if (tx_seen.size() - first < count) begin
			$display("Timeout while collecting %0d transmit bytes", count);
			timeouts++;
		end
		tx_byte_ready = 1'b1;
		repeat (8) step(); // A byte beyond the count would be caught here
		tx_byte_ready = 1'b0;
		check_eq("tx byte count", 48'(count), 48'(tx_seen.size() - first));
		for (i = 0; i < count && first + i < tx_seen.size(); i++)
			check_eq("tx_byte", 48'(tx_words[i / 4][8 * (i % 4) +: 8]), 48'(tx_seen[first + i]));
		csr_read(minimac_pkg::REG_TX_COUNT, data);
		check_eq("REG_TX_COUNT", 48'd0, 48'(data));
		check_eq("irq_tx pulses", 48'd1, 48'(irq_tx_pulses - pulses0));
	endtask

	initial begin
		logic [31:0] data;
		int          count;
		int          i;
		seed          = 32'h3377f39c;
		errors        = 0;
		timeouts      = 0;
		irq_tx_pulses = 0;
		sys_rst       = 1'b1;
		csr_a         = '0;
		csr_we        = 1'b0;
		csr_di        = '0;
		mdio_i        = 1'b0;
		mem_we        = 1'b0;
		mem_a         = '0;
		mem_di        = '0;
		rx_byte       = '0;
		rx_byte_valid = 1'b0;
		rx_byte_last  = 1'b0;
		tx_byte_ready = 1'b0;
		repeat (5) step();
		sys_rst = 1'b0;

		check_eq("irq_rx", 48'd0, 48'(irq_rx));
		check_eq("irq_tx", 48'd0, 48'(irq_tx));
		check_eq("mdio_oe", 48'd0, 48'(mdio_oe));
		check_eq("mdc", 48'd0, 48'(mdc));
		check_eq("rx_byte_ready", 48'd0, 48'(rx_byte_ready));
		check_eq("tx_byte_valid", 48'd0, 48'(tx_byte_valid));
		csr_read(minimac_pkg::REG_MAC_HI, data);
		check_eq("REG_MAC_HI", 48'(minimac_pkg::DEFAULT_MACADDR[47:24]), 48'(data));
		csr_read(minimac_pkg::REG_MAC_LO, data);
		check_eq("REG_MAC_LO", 48'(minimac_pkg::DEFAULT_MACADDR[23:0]), 48'(data));
		csr_write(minimac_pkg::REG_CTRL, 32'd3);
		csr_write(minimac_pkg::REG_MAC_HI, 32'h0012_3456);
		csr_write(minimac_pkg::REG_MAC_LO, 32'h0078_9abc);
		check_eq("speed10", 48'd1, 48'(speed10));
		check_eq("promisc", 48'd1, 48'(promisc));
		check_eq("macaddr", 48'h1234_5678_9abc, macaddr);
		csr_read(minimac_pkg::REG_CTRL, data);
		check_eq("REG_CTRL", 48'd3, 48'(data));
		csr_read(minimac_pkg::REG_MAC_HI, data);
		check_eq("REG_MAC_HI", 48'h12_3456, 48'(data));
		csr_read(minimac_pkg::REG_MAC_LO, data);
		check_eq("REG_MAC_LO", 48'h78_9abc, 48'(data));

		// MDIO pins follow the register and the input comes back on bit 1
		csr_write(minimac_pkg::REG_MDIO, 32'hd);
		check_eq("mdc", 48'd1, 48'(mdc));
		check_eq("mdio_oe", 48'd1, 48'(mdio_oe));
		check_eq("mdio_o", 48'd1, 48'(mdio_o));
		csr_read(minimac_pkg::REG_MDIO, data);
		check_eq("REG_MDIO", 48'hd, 48'(data)); // Input still low here
		mdio_i = 1'b1;
		repeat (3) step();
		csr_read(minimac_pkg::REG_MDIO, data);
		check_eq("REG_MDIO", 48'hf, 48'(data));

		csr_write(slot_field(0, 1), 32'(SLOT0_WORD * 4));
		csr_write(slot_field(1, 1), 32'(SLOT1_WORD * 4));
		csr_write(slot_field(0, 0), 32'(minimac_pkg::SLOT_LOADED));
		csr_write(slot_field(1, 0), 32'(minimac_pkg::SLOT_LOADED));
		make_frame();
		send_frame();
		wait_slot_done(0);
		check_slot(0, SLOT0_WORD);
		check_eq("irq_rx", 48'd1, 48'(irq_rx));
		make_frame();
		send_frame();
		wait_slot_done(1); // Slot 0 is DONE so slot 1 is next in line
		check_slot(1, SLOT1_WORD);
		csr_write(slot_field(0, 0), 32'(minimac_pkg::SLOT_FREE));
		csr_write(slot_field(1, 0), 32'(minimac_pkg::SLOT_FREE));
		step();
		check_eq("irq_rx", 48'd0, 48'(irq_rx));

		/* No slot holds a buffer, so offered bytes must be refused */
		rx_byte       = 8'h55;
		rx_byte_valid = 1'b1;
		repeat (50) begin
			check_eq("rx_byte_ready", 48'd0, 48'(rx_byte_ready));
			step();
		end
		rx_byte_valid = 1'b0;
		for (i = 0; i < minimac_pkg::NUM_SLOTS; i++) begin
			csr_read(slot_field(i, 2), data);
			check_eq("slot count", 48'd0, 48'(data));
		end

		fill_tx_words();
		count = 1 + int'(next_rand() >> 8) % 40;
		run_tx(count);

		// Transmit and receive share the DMA port of the buffer
		fill_tx_words();
		csr_write(slot_field(2, 1), 32'(SLOT2_WORD * 4));
		csr_write(slot_field(2, 0), 32'(minimac_pkg::SLOT_LOADED));
		make_frame();
		count = 1 + int'(next_rand() >> 8) % 40;
		fork
			send_frame();
			run_tx(count);
		join
		wait_slot_done(2);
		check_slot(2, SLOT2_WORD);

		$display("Finished with %0d failed checks and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: minimac.f
source/minimac_pkg.sv
source/minimac_ctlif.sv
source/minimac_rx.sv
source/minimac_tx.sv
source/minimac_buffer.sv
source/minimac.sv
testbench/tb_minimac.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the MAC testbench with Verilator, run it and judge the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f minimac.f --top-module tb_minimac -o tb_minimac

output=$(./obj_dir/tb_minimac)
echo "$output"

if echo "$output" | grep -q "Everything OK"; then
	exit 0
else
	exit 1
fi
